// ==== Makefile ====
TOP = exec_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -f exec_unit.f --top-module exec_unit

sim:
	verilator --binary --timing --assert -f exec_unit.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== exec_unit.f ====
rtl/cpu_data_pkg.sv
rtl/cpu_op_pkg.sv
rtl/alu_unit.sv
rtl/div_unit.sv
rtl/hilo_commit.sv
rtl/exec_unit.sv
test/exec_unit_tb.sv

// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 valid_i,
    input  wire cpu_op_pkg::alu_op_e  op_i,
    input  wire cpu_data_pkg::word_t  operand_a_i,
    input  wire cpu_data_pkg::word_t  operand_b_i,
    output logic                      done_o,
    output cpu_data_pkg::word_t       lo_o,
    output cpu_data_pkg::word_t       hi_o,
    output logic                      write_hilo_o
);

    import cpu_data_pkg::*;
    import cpu_op_pkg::*;

    logic                  is_div;
    logic                  is_mult;
    logic [WORD_IDX_W-1:0] shamt;
    dword_t                mul_a;
    dword_t                mul_b;
    dword_t                product;
    word_t                 lo_d;

    assign is_div  = (op_i == OP_DIV) || (op_i == OP_DIVU);
    assign is_mult = (op_i == OP_MULT) || (op_i == OP_MULTU);
    assign shamt   = operand_b_i[WORD_IDX_W-1:0];

    // sign extend for MULT, low half of the product is then the signed product
    assign mul_a = (op_i == OP_MULT) ? {{WORD_W{operand_a_i[WORD_W-1]}}, operand_a_i}
                                     : {{WORD_W{1'b0}}, operand_a_i};
    assign mul_b = (op_i == OP_MULT) ? {{WORD_W{operand_b_i[WORD_W-1]}}, operand_b_i}
                                     : {{WORD_W{1'b0}}, operand_b_i};
    assign product = mul_a * mul_b;

    always_comb begin
        case (op_i)
            OP_ADDU:  lo_d = operand_a_i + operand_b_i;
            OP_SUBU:  lo_d = operand_a_i - operand_b_i;
            OP_AND:   lo_d = operand_a_i & operand_b_i;
            OP_OR:    lo_d = operand_a_i | operand_b_i;
            OP_XOR:   lo_d = operand_a_i ^ operand_b_i;
            OP_NOR:   lo_d = ~(operand_a_i | operand_b_i);
            OP_SLT:   lo_d = word_t'($signed(operand_a_i) < $signed(operand_b_i));
            OP_SLTU:  lo_d = word_t'(operand_a_i < operand_b_i);
            OP_SLL:   lo_d = operand_a_i << shamt;
            OP_SRL:   lo_d = operand_a_i >> shamt;
            OP_SRA:   lo_d = word_t'($signed(operand_a_i) >>> shamt);
            OP_MULT,
            OP_MULTU: lo_d = product[WORD_W-1:0];
            // divides belong to div_unit
            default:  lo_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_o       <= 1'b0;
            write_hilo_o <= 1'b0;
        end else begin
            done_o       <= valid_i && !is_div;
            write_hilo_o <= valid_i && is_mult;
        end
    end

    always_ff @(posedge clk) begin
        lo_o <= lo_d;
        hi_o <= product[DWORD_W-1:WORD_W];
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_data_pkg.sv ====
`default_nettype none

package cpu_data_pkg;

    // machine word of the MIPS datapath
    localparam int WORD_W = 32;

    // full product of two words
    localparam int DWORD_W = 2 * WORD_W;

    // bits needed to index a bit of a word
    localparam int WORD_IDX_W = $clog2(WORD_W);

    // operands, results, HI and LO
    typedef logic [WORD_W-1:0] word_t;

    // multiplier product, HI in the upper half
    typedef logic [DWORD_W-1:0] dword_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_op_pkg.sv ====
`default_nettype none

package cpu_op_pkg;

    // execute unit opcodes
    typedef enum logic [3:0] {
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU
    } alu_op_e;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_e;

endpackage

`default_nettype wire

// ==== rtl/div_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_unit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 valid_i,
    input  wire cpu_op_pkg::alu_op_e  op_i,
    input  wire cpu_data_pkg::word_t  dividend_i,
    input  wire cpu_data_pkg::word_t  divisor_i,
    output logic                      done_o,
    output cpu_data_pkg::word_t       quotient_o,
    output cpu_data_pkg::word_t       remainder_o,
    output logic                      busy_o
);

    import cpu_data_pkg::*;
    import cpu_op_pkg::*;

    div_state_e            state;
    logic [WORD_IDX_W-1:0] count;
    logic                  start;
    logic                  is_signed;
    word_t                 dividend_mag;
    word_t                 divisor_mag;
    word_t                 quot_q;
    word_t                 rem_q;
    word_t                 divisor_q;
    logic                  neg_quot;
    logic                  neg_rem;
    logic [WORD_W:0]       trial;

    assign start     = valid_i && ((op_i == OP_DIV) || (op_i == OP_DIVU));
    assign is_signed = (op_i == OP_DIV);
    assign busy_o    = (state != DIV_IDLE);

    // magnitudes for a signed divide, signs are put back in DIV_FIX
    assign dividend_mag = (is_signed && dividend_i[WORD_W-1]) ? -dividend_i : dividend_i;
    assign divisor_mag  = (is_signed && divisor_i[WORD_W-1]) ? -divisor_i : divisor_i;

    // shift next dividend bit into the partial remainder and try subtracting
    assign trial = {rem_q, quot_q[WORD_W-1]} - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= DIV_IDLE;
            count  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    count <= '0;
                    if (start) begin
                        // zero divisor answers at once
                        if (divisor_i == '0) begin
                            done_o <= 1'b1;
                        end else begin
                            state <= DIV_RUN;
                        end
                    end
                end
                DIV_RUN: begin
                    count <= count + 1'b1;
                    // last of the WORD_W iterations
                    if (count == '1) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state  <= DIV_IDLE;
                    done_o <= 1'b1;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    quotient_o  <= '1;
                    remainder_o <= dividend_i;
                    quot_q      <= dividend_mag;
                    rem_q       <= '0;
                    divisor_q   <= divisor_mag;
                    neg_quot    <= is_signed && (dividend_i[WORD_W-1] ^ divisor_i[WORD_W-1]);
                    neg_rem     <= is_signed && dividend_i[WORD_W-1];
                end
            end
            DIV_RUN: begin
                if (!trial[WORD_W]) begin
                    rem_q  <= trial[WORD_W-1:0];
                    quot_q <= {quot_q[WORD_W-2:0], 1'b1};
                end else begin
                    rem_q  <= {rem_q[WORD_W-2:0], quot_q[WORD_W-1]};
                    quot_q <= {quot_q[WORD_W-2:0], 1'b0};
                end
            end
            DIV_FIX: begin
                quotient_o  <= neg_quot ? -quot_q : quot_q;
                remainder_o <= neg_rem ? -rem_q : rem_q;
            end
            default: ;
        endcase
    end

    // source must hold off while a divide is in flight
    a_no_valid_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy_o |-> !valid_i)
        else $error("valid_i offered while divider busy in %s", state.name());

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 valid_i,
    input  wire cpu_op_pkg::alu_op_e  op_i,
    input  wire cpu_data_pkg::word_t  operand_a_i,
    input  wire cpu_data_pkg::word_t  operand_b_i,
    output logic                      done_o,
    output cpu_data_pkg::word_t       result_o,
    output cpu_data_pkg::word_t       hi_o,
    output cpu_data_pkg::word_t       lo_o,
    output logic                      busy_o
);

    import cpu_data_pkg::*;

    logic  alu_done;
    word_t alu_lo;
    word_t alu_hi;
    logic  alu_write_hilo;
    logic  div_done;
    word_t quotient;
    word_t remainder;

    // each unit picks out its own opcodes
    alu_unit alu_unit_i (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .done_o       (alu_done),
        .lo_o         (alu_lo),
        .hi_o         (alu_hi),
        .write_hilo_o (alu_write_hilo)
    );

    div_unit div_unit_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .dividend_i  (operand_a_i),
        .divisor_i   (operand_b_i),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .busy_o      (busy_o)
    );

    hilo_commit hilo_commit_i (
        .clk              (clk),
        .rst              (rst),
        .alu_done_i       (alu_done),
        .alu_lo_i         (alu_lo),
        .alu_hi_i         (alu_hi),
        .alu_write_hilo_i (alu_write_hilo),
        .div_done_i       (div_done),
        .quotient_i       (quotient),
        .remainder_i      (remainder),
        .done_o           (done_o),
        .result_o         (result_o),
        .hi_o             (hi_o),
        .lo_o             (lo_o)
    );

endmodule

`default_nettype wire

// ==== rtl/hilo_commit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hilo_commit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 alu_done_i,
    input  wire cpu_data_pkg::word_t  alu_lo_i,
    input  wire cpu_data_pkg::word_t  alu_hi_i,
    input  wire logic                 alu_write_hilo_i,
    input  wire logic                 div_done_i,
    input  wire cpu_data_pkg::word_t  quotient_i,
    input  wire cpu_data_pkg::word_t  remainder_i,
    output logic                      done_o,
    output cpu_data_pkg::word_t       result_o,
    output cpu_data_pkg::word_t       hi_o,
    output cpu_data_pkg::word_t       lo_o
);

    import cpu_data_pkg::*;

    logic  write_hilo;
    word_t result_d;
    word_t hi_d;

    // at most one unit finishes per cycle
    assign result_d   = div_done_i ? quotient_i : alu_lo_i;
    assign hi_d       = div_done_i ? remainder_i : alu_hi_i;
    assign write_hilo = div_done_i || (alu_done_i && alu_write_hilo_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            done_o   <= 1'b0;
            result_o <= '0;
            hi_o     <= '0;
            lo_o     <= '0;
        end else begin
            done_o <= alu_done_i || div_done_i;
            if (alu_done_i || div_done_i) begin
                result_o <= result_d;
            end
            // LO always mirrors the result word of a multiply or divide
            if (write_hilo) begin
                hi_o <= hi_d;
                lo_o <= result_d;
            end
        end
    end

    // busy back-pressure keeps the two streams apart
    a_single_done: assert property (@(posedge clk) disable iff (rst)
        !(alu_done_i && div_done_i))
        else $error("alu and divider finished in the same cycle");

endmodule

`default_nettype wire

// ==== test/exec_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb;

    import cpu_data_pkg::*;
    import cpu_op_pkg::*;

    localparam int MAX_ENTRIES  = 64;
    localparam int RAND_ENTRIES = 40;

    logic    clk = 1'b0;
    logic    rst = 1'b1;
    logic    valid_i = 1'b0;
    alu_op_e op_i = OP_ADDU;
    word_t   operand_a_i = '0;
    word_t   operand_b_i = '0;
    logic    done_o;
    word_t   result_o;
    word_t   hi_o;
    word_t   lo_o;
    logic    busy_o;

    alu_op_e tab_op  [MAX_ENTRIES];
    word_t   tab_a   [MAX_ENTRIES];
    word_t   tab_b   [MAX_ENTRIES];
    word_t   tab_res [MAX_ENTRIES];
    word_t   tab_hi  [MAX_ENTRIES];
    word_t   tab_lo  [MAX_ENTRIES];
    int      n_entries = 0;
    logic    table_ready = 1'b0;
    word_t   lfsr = 32'hd6eebfd7;
    word_t   model_hi;
    word_t   model_lo;
    int      cycle = 0;
    int      pend_idx[$];
    int      pend_cyc[$];
    int      fall_cyc = 0;
    int      value_errs = 0;
    int      other_errs = 0;

    exec_unit exec_unit_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t lfsr_next(input word_t s);
        // taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[WORD_W-2:0], lfsr[0]};
        end
    endtask

    // reference behavior, keeps its own HI and LO
    task automatic model_op(input alu_op_e op, input word_t a, input word_t b,
                            output word_t res);
        dword_t wide;
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        wide = '0;
        case (op)
            OP_ADDU: res = a + b;
            OP_SUBU: res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            OP_SLT:  res = (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP_SLL:  res = a << b[4:0];
            OP_SRL:  res = a >> b[4:0];
            OP_SRA: begin
                wide = {{WORD_W{a[WORD_W-1]}}, a} >> b[4:0];
                res = wide[WORD_W-1:0];
            end
            OP_MULT, OP_MULTU: begin
                if (op == OP_MULT) wide = dword_t'(sa * sb);
                else wide = {32'b0, a} * {32'b0, b};
                model_hi = wide[63:32];
                model_lo = wide[31:0];
                res = model_lo;
            end
            default: begin
                if (b == '0) begin
                    model_lo = '1;
                    model_hi = a;
                end else if (op == OP_DIV) begin
                    model_lo = word_t'(sa / sb);
                    model_hi = word_t'(sa % sb);
                end else begin
                    model_lo = a / b;
                    model_hi = a % b;
                end
                res = model_lo;
            end
        endcase
    endtask

    task automatic add_entry(input alu_op_e op, input word_t a, input word_t b,
                             input word_t res, input word_t hi, input word_t lo);
        tab_op[n_entries] = op;
        tab_a[n_entries] = a;
        tab_b[n_entries] = b;
        tab_res[n_entries] = res;
        tab_hi[n_entries] = hi;
        tab_lo[n_entries] = lo;
        n_entries++;
    endtask

    function automatic logic is_long_div(input int idx);
        return (tab_op[idx] == OP_DIV || tab_op[idx] == OP_DIVU) && tab_b[idx] != '0;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_hilo(input word_t got_hi, input word_t got_lo,
                              input word_t exp_hi, input word_t exp_lo);
        check_word("hi_o", got_hi, exp_hi);
        check_word("lo_o", got_lo, exp_lo);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic flag_protocol(input string msg);
        $display("%s", msg);
        other_errs++;
    endtask

    // completion and busy checker, outputs settle before the falling edge
    always @(negedge clk) begin
        int idx;
        int age;
        if (pend_idx.size() > 0) begin
            idx = pend_idx[0];
            age = cycle - pend_cyc[0];
            if (done_o) begin
                pend_idx.delete(0);
                pend_cyc.delete(0);
                if (!is_long_div(idx) && age != 2)
                    flag_protocol($sformatf("entry %0d finished after %0d cycles", idx, age));
                if (is_long_div(idx) && fall_cyc != cycle - 1)
                    flag_protocol($sformatf("entry %0d: busy_o did not fall before done_o", idx));
                check_word("result_o", result_o, tab_res[idx]);
                check_hilo(hi_o, lo_o, tab_hi[idx], tab_lo[idx]);
            end else if (!is_long_div(idx) && age >= 2) begin
                pend_idx.delete(0);
                pend_cyc.delete(0);
                flag_protocol($sformatf("entry %0d never raised done_o", idx));
            end else if (is_long_div(idx) && age >= 1) begin
                if (age == 1 && !busy_o)
                    flag_protocol($sformatf("entry %0d: busy_o did not rise", idx));
                else if (busy_o && fall_cyc > pend_cyc[0])
                    flag_protocol($sformatf("entry %0d: busy_o rose again", idx));
                else if (!busy_o && fall_cyc <= pend_cyc[0])
                    fall_cyc = cycle;
            end
        end else if (done_o === 1'b1) begin
            flag_protocol("done_o pulsed with nothing outstanding");
        end
    end

    initial begin
        wait (table_ready);
        repeat (n_entries * 40 + 20) @(posedge clk);
        $display("run timed out before all operations finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        word_t   a;
        word_t   b;
        word_t   v;
        word_t   res;
        alu_op_e op;
        add_entry(OP_ADDU,  32'h7fffffff, 32'h00000001, 32'h80000000, 32'h0, 32'h0);
        add_entry(OP_SUBU,  32'h00000005, 32'h00000007, 32'hfffffffe, 32'h0, 32'h0);
        add_entry(OP_AND,   32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000, 32'h0, 32'h0);
        add_entry(OP_OR,    32'hf0f00000, 32'h0000ff0f, 32'hf0f0ff0f, 32'h0, 32'h0);
        add_entry(OP_XOR,   32'haaaa5555, 32'hffff0000, 32'h55555555, 32'h0, 32'h0);
        add_entry(OP_NOR,   32'h0f0f0f0f, 32'h30303030, 32'hc0c0c0c0, 32'h0, 32'h0);
        add_entry(OP_SLT,   32'hffffffff, 32'h00000001, 32'h00000001, 32'h0, 32'h0);
        add_entry(OP_SLTU,  32'hffffffff, 32'h00000001, 32'h00000000, 32'h0, 32'h0);
        add_entry(OP_SLL,   32'h00000003, 32'h00000024, 32'h00000030, 32'h0, 32'h0);
        add_entry(OP_SRL,   32'h80000000, 32'h0000001f, 32'h00000001, 32'h0, 32'h0);
        add_entry(OP_SRA,   32'h80000010, 32'h00000004, 32'hf8000001, 32'h0, 32'h0);
        add_entry(OP_MULT,  32'hfffffffe, 32'h00000003, 32'hfffffffa, 32'hffffffff, 32'hfffffffa);
        add_entry(OP_MULT,  32'h80000000, 32'h80000000, 32'h00000000, 32'h40000000, 32'h0);
        add_entry(OP_MULTU, 32'hffffffff, 32'hffffffff, 32'h00000001, 32'hfffffffe, 32'h1);
        add_entry(OP_ADDU,  32'h00000001, 32'h00000002, 32'h00000003, 32'hfffffffe, 32'h1);
        add_entry(OP_DIV,   32'hfffffff9, 32'h00000002, 32'hfffffffd, 32'hffffffff, 32'hfffffffd);
        add_entry(OP_DIV,   32'h00000007, 32'hfffffffe, 32'hfffffffd, 32'h00000001, 32'hfffffffd);
        add_entry(OP_DIV,   32'hfffffff9, 32'hfffffffe, 32'h00000003, 32'hffffffff, 32'h3);
        add_entry(OP_DIV,   32'h00000064, 32'h00000007, 32'h0000000e, 32'h00000002, 32'he);
        add_entry(OP_DIVU,  32'hfffffff9, 32'h00000002, 32'h7ffffffc, 32'h00000001, 32'h7ffffffc);
        add_entry(OP_DIV,   32'h00001234, 32'h00000000, 32'hffffffff, 32'h00001234, 32'hffffffff);
        add_entry(OP_DIVU,  32'hdeadbeef, 32'h00000000, 32'hffffffff, 32'hdeadbeef, 32'hffffffff);
        model_hi = tab_hi[n_entries-1];
        model_lo = tab_lo[n_entries-1];
        for (int i = 0; i < RAND_ENTRIES; i++) begin
            take_bits(4, v);
            op = alu_op_e'(4'(v % 15));
            take_bits(WORD_W, a);
            take_bits(WORD_W, b);
            model_op(op, a, b, res);
            add_entry(op, a, b, res, model_hi, model_lo);
        end
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("done_o", done_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);
        check_word("result_o", result_o, '0);
        check_hilo(hi_o, lo_o, '0, '0);
        // ALU entries go out back to back
        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            valid_i <= 1'b1;
            op_i <= tab_op[i];
            operand_a_i <= tab_a[i];
            operand_b_i <= tab_b[i];
            pend_idx.push_back(i);
            pend_cyc.push_back(cycle + 1);
            if (tab_op[i] == OP_DIV || tab_op[i] == OP_DIVU) begin
                @(posedge clk);
                valid_i <= 1'b0;
                while (pend_idx.size() != 0) @(posedge clk);
            end
        end
        @(posedge clk);
        valid_i <= 1'b0;
        while (pend_idx.size() != 0) @(posedge clk);
        $display("value errors: %0d, protocol errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
